//--- flist.f
+incdir+verilog
+incdir+test
verilog/eth_pkg.sv
verilog/rx_byte_if.sv
verilog/rgmii_rx_framer.sv
verilog/header_parser.sv
verilog/crc_checker.sv
verilog/rx_status_regs.sv
verilog/rgmii_port.sv
test/tb_rgmii_port.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_rgmii_port
FLIST     = flist.f
OBJ_DIR   = obj_dir

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FLIST))
HEADERS   = $(wildcard verilog/*.svh test/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_tasks.svh
//////////////////////////////////////////////////
// Compare, APB access
//////////////////////////////////////////////////

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
    if (got !== expected) begin
        fail_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, expected));
    end
endtask

task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clock);
    penable <= 1'b1;
    // Register is written on this edge
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clock);
    penable <= 1'b1;
    // Read data is combinational in the access phase
    @(negedge clock);
    data = prdata;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

task automatic read_counts(output logic [31:0] valid_cnt, output logic [31:0] invalid_cnt);
    apb_read(`REG_VALID_COUNT, valid_cnt);
    apb_read(`REG_INVALID_COUNT, invalid_cnt);
endtask

//////////////////////////////////////////////////
// Frame building and CRC
//////////////////////////////////////////////////

// Bit serial, LSB first, inverted at the end for the FCS
task automatic compute_fcs(output logic [31:0] fcs);
    logic [31:0] lfsr;
    logic [7:0]  data;
    logic        feedback;
    lfsr = 32'hFFFFFFFF;
    foreach (frame_q[i]) begin
        data = frame_q[i];
        for (int b = 0; b < 8; b++) begin
            feedback = lfsr[0] ^ data[0];
            lfsr     = lfsr >> 1;
            data     = data >> 1;
            if (feedback) begin
                lfsr = lfsr ^ 32'hEDB88320;
            end
        end
    end
    fcs = ~lfsr;
endtask

// Length counts addresses through FCS
task automatic build_frame(input logic [47:0] dest, input logic [47:0] src, input int length);
    logic [31:0] fcs;
    frame_q.delete();
    for (int i = 0; i < 6; i++) begin
        frame_q.push_back(dest[47:40]);
        dest = dest << 8;
    end
    for (int i = 0; i < 6; i++) begin
        frame_q.push_back(src[47:40]);
        src = src << 8;
    end
    while (frame_q.size() < length - 4) begin
        frame_q.push_back(8'($random(seed)));
    end
    compute_fcs(fcs);
    // FCS goes out least significant byte first
    for (int i = 0; i < 4; i++) begin
        frame_q.push_back(fcs[7:0]);
        fcs = fcs >> 8;
    end
endtask

//////////////////////////////////////////////////
// PHY side drive and verdict checks
//////////////////////////////////////////////////

task automatic drive_nibble(input logic [3:0] nibble);
    @(posedge clock);
    phy_rx_data_enable <= 1'b1;
    phy_rx_data        <= nibble;
endtask

task automatic drive_byte(input logic [7:0] value);
    drive_nibble(value[3:0]);
    drive_nibble(value[7:4]);
endtask

task automatic send_frame(input bit extra_nibble);
    for (int i = 0; i < 7; i++) begin
        drive_byte(`ETH_PREAMBLE_BYTE);
    end
    drive_byte(`ETH_SFD);
    foreach (frame_q[i]) begin
        drive_byte(frame_q[i]);
    end
    if (extra_nibble) begin
        drive_nibble(4'hA);
    end
    @(posedge clock);
    phy_rx_data_enable <= 1'b0;
    phy_rx_data        <= 4'd0;
endtask

task automatic expect_pulse(input logic expect_valid);
    int cycles;
    cycles = 0;
    while (!valid_packet && !invalid_packet) begin
        if (cycles == TIMEOUT_CYCLES) begin
            fail_run("Timeout: no valid_packet or invalid_packet pulse after the frame");
        end
        @(negedge clock);
        cycles++;
    end
    check_value("valid_packet", 64'(valid_packet), 64'(expect_valid));
    check_value("invalid_packet", 64'(invalid_packet), 64'(!expect_valid));
endtask

task automatic confirm_no_pulse(input int cycles);
    for (int i = 0; i < cycles; i++) begin
        @(negedge clock);
        if (valid_packet || invalid_packet) begin
            fail_run("A packet pulse appeared while the port was disabled");
        end
    end
endtask

// Sends frame_q and checks the pulse and both counters
task automatic send_and_check(input bit extra_nibble, input logic expect_valid);
    logic [31:0] valid_before;
    logic [31:0] invalid_before;
    logic [31:0] valid_after;
    logic [31:0] invalid_after;
    read_counts(valid_before, invalid_before);
    send_frame(extra_nibble);
    expect_pulse(expect_valid);
    read_counts(valid_after, invalid_after);
    check_value("VALID_COUNT", 64'(valid_after), 64'(valid_before + 32'(expect_valid)));
    check_value("INVALID_COUNT", 64'(invalid_after), 64'(invalid_before + 32'(!expect_valid)));
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic good_frame_to_station();
    apb_write(`REG_STATION_LO, STATION_MAC[31:0]);
    apb_write(`REG_STATION_HI, {16'd0, STATION_MAC[47:32]});
    // Port enabled, filter on
    apb_write(`REG_CTRL, 32'h3);
    build_frame(STATION_MAC, SOURCE_MAC, 64);
    send_and_check(1'b0, 1'b1);
    check_value("parsed_mac_destination", 64'(parsed_mac_destination), 64'(STATION_MAC));
    check_value("parsed_mac_source", 64'(parsed_mac_source), 64'(SOURCE_MAC));
endtask

task automatic corrupted_payload();
    // Reuses the previous frame
    frame_q[20] = frame_q[20] ^ 8'hFF;
    send_and_check(1'b0, 1'b0);
endtask

task automatic short_frame_rejected();
    build_frame(STATION_MAC, SOURCE_MAC, 60);
    send_and_check(1'b0, 1'b0);
endtask

task automatic address_filtering();
    build_frame(FOREIGN_MAC, SOURCE_MAC, 64);
    send_and_check(1'b0, 1'b0);
    // Filtered frame leaves the short frame's addresses in place
    check_value("parsed_mac_destination", 64'(parsed_mac_destination), 64'(STATION_MAC));
    build_frame(BROADCAST_MAC, SOURCE_MAC, 64);
    send_and_check(1'b0, 1'b1);
    check_value("parsed_mac_destination", 64'(parsed_mac_destination), 64'(BROADCAST_MAC));
    apb_write(`REG_CTRL, 32'h1);
    build_frame(FOREIGN_MAC, SOURCE_MAC, 64);
    send_and_check(1'b0, 1'b1);
    check_value("parsed_mac_destination", 64'(parsed_mac_destination), 64'(FOREIGN_MAC));
    apb_write(`REG_CTRL, 32'h3);
endtask

task automatic odd_nibble_count();
    build_frame(STATION_MAC, SOURCE_MAC, 64);
    send_and_check(1'b1, 1'b0);
endtask

task automatic disabled_port_ignores_frame();
    logic [31:0] valid_before;
    logic [31:0] invalid_before;
    logic [31:0] valid_after;
    logic [31:0] invalid_after;
    apb_write(`REG_CTRL, 32'h2);
    read_counts(valid_before, invalid_before);
    build_frame(STATION_MAC, SOURCE_MAC, 64);
    send_frame(1'b0);
    confirm_no_pulse(TIMEOUT_CYCLES);
    read_counts(valid_after, invalid_after);
    check_value("VALID_COUNT", 64'(valid_after), 64'(valid_before));
    check_value("INVALID_COUNT", 64'(invalid_after), 64'(invalid_before));
endtask

//--- test/tb_rgmii_port.sv
`include "eth_defines.svh"

module tb_rgmii_port;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam logic [47:0] STATION_MAC    = 48'h02005E102030;
    localparam logic [47:0] SOURCE_MAC     = 48'h02ABCDEF0123;
    localparam logic [47:0] FOREIGN_MAC    = 48'h029988776655;
    localparam logic [47:0] BROADCAST_MAC  = 48'hFFFFFFFFFFFF;

    logic        clock;
    logic        rst_n;
    logic        phy_rx_data_enable;
    logic [3:0]  phy_rx_data;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        valid_packet;
    logic        invalid_packet;
    logic [47:0] parsed_mac_destination;
    logic [47:0] parsed_mac_source;

    integer      seed;
    // Frame bytes from destination address through FCS
    logic [7:0]  frame_q[$];

    rgmii_port dut (
        .clock                  (clock),
        .rst_n                  (rst_n),
        .phy_rx_data_enable     (phy_rx_data_enable),
        .phy_rx_data            (phy_rx_data),
        .psel                   (psel),
        .penable                (penable),
        .pwrite                 (pwrite),
        .paddr                  (paddr),
        .pwdata                 (pwdata),
        .prdata                 (prdata),
        .valid_packet           (valid_packet),
        .invalid_packet         (invalid_packet),
        .parsed_mac_destination (parsed_mac_destination),
        .parsed_mac_source      (parsed_mac_source)
    );

    `include "tb_tasks.svh"

    always #5 clock = ~clock;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    //////////////////////////////////////////////////
    // Reset and test sequence
    //////////////////////////////////////////////////
    initial begin
        seed               = 49195;
        clock              = 1'b0;
        rst_n              <= 1'b0;
        phy_rx_data_enable <= 1'b0;
        phy_rx_data        <= 4'd0;
        psel               <= 1'b0;
        penable            <= 1'b0;
        pwrite             <= 1'b0;
        paddr              <= 8'd0;
        pwdata             <= 32'd0;

        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        @(posedge clock);

        good_frame_to_station();
        corrupted_payload();
        short_frame_rejected();
        address_filtering();
        odd_nibble_count();
        // Leaves the port disabled
        disabled_port_ignores_frame();

        $display("Test OK");
        $finish;
    end

endmodule

//--- verilog/rgmii_port.sv
module rgmii_port (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        phy_rx_data_enable,
    input  logic [3:0]  phy_rx_data,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        valid_packet,
    output logic        invalid_packet,
    output logic [47:0] parsed_mac_destination,
    output logic [47:0] parsed_mac_source
);

    logic        enable;
    logic [47:0] dest_mac;
    logic [47:0] src_mac;
    logic        short_frame;
    logic        parse_done;
    logic        crc_ok;
    logic        crc_done;

    // Frame bytes shared by both checkers
    rx_byte_if rx_bus ();

    rgmii_rx_framer rgmii_rx_framer (
        .clock              (clock),
        .rst_n              (rst_n),
        .enable             (enable),
        .phy_rx_data_enable (phy_rx_data_enable),
        .phy_rx_data        (phy_rx_data),
        .rx                 (rx_bus.source)
    );

    header_parser header_parser (
        .clock       (clock),
        .rst_n       (rst_n),
        .rx          (rx_bus.sink),
        .dest_mac    (dest_mac),
        .src_mac     (src_mac),
        .short_frame (short_frame),
        .done        (parse_done)
    );

    crc_checker crc_checker (
        .clock  (clock),
        .rst_n  (rst_n),
        .rx     (rx_bus.sink),
        .crc_ok (crc_ok),
        .done   (crc_done)
    );

    rx_status_regs rx_status_regs (
        .clock                  (clock),
        .rst_n                  (rst_n),
        .dest_mac               (dest_mac),
        .src_mac                (src_mac),
        .short_frame            (short_frame),
        .parse_done             (parse_done),
        .crc_ok                 (crc_ok),
        .crc_done               (crc_done),
        .align_error            (rx_bus.align_error),
        .psel                   (psel),
        .penable                (penable),
        .pwrite                 (pwrite),
        .paddr                  (paddr),
        .pwdata                 (pwdata),
        .prdata                 (prdata),
        .enable                 (enable),
        .valid_packet           (valid_packet),
        .invalid_packet         (invalid_packet),
        .parsed_mac_destination (parsed_mac_destination),
        .parsed_mac_source      (parsed_mac_source)
    );

endmodule

//--- verilog/rx_status_regs.sv
`include "eth_defines.svh"

module rx_status_regs import eth_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  logic [47:0] dest_mac,
    input  logic [47:0] src_mac,
    input  logic        short_frame,
    input  logic        parse_done,
    input  logic        crc_ok,
    input  logic        crc_done,
    input  logic        align_error,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        enable,
    output logic        valid_packet,
    output logic        invalid_packet,
    output logic [47:0] parsed_mac_destination,
    output logic [47:0] parsed_mac_source
);

    // ctrl[0] port enable, ctrl[1] address filter
    logic [1:0]  ctrl;
    logic [47:0] station_mac;
    logic [31:0] valid_count;
    logic [31:0] invalid_count;
    logic        align_seen;
    logic        frame_done;
    logic        filter_pass;
    logic        frame_good;
    apb_reg_e    reg_sel;

    assign enable     = ctrl[0];
    assign frame_done = parse_done && crc_done;

    // Station address or broadcast passes when filtering
    assign filter_pass = !ctrl[1] || dest_mac == station_mac || dest_mac == 48'hFFFFFFFFFFFF;
    assign frame_good  = crc_ok && !short_frame && !align_seen && filter_pass;

    ////////////////////////////////////////////////
    // APB decode and read mux
    ////////////////////////////////////////////////
    always_comb begin
        case (paddr)
            `REG_CTRL:          reg_sel = SEL_CTRL;
            `REG_STATION_LO:    reg_sel = SEL_STATION_LO;
            `REG_STATION_HI:    reg_sel = SEL_STATION_HI;
            `REG_VALID_COUNT:   reg_sel = SEL_VALID_COUNT;
            `REG_INVALID_COUNT: reg_sel = SEL_INVALID_COUNT;
            `REG_DEST_LO:       reg_sel = SEL_DEST_LO;
            `REG_DEST_HI:       reg_sel = SEL_DEST_HI;
            `REG_SRC_LO:        reg_sel = SEL_SRC_LO;
            `REG_SRC_HI:        reg_sel = SEL_SRC_HI;
            default:            reg_sel = SEL_NONE;
        endcase
    end

    always_comb begin
        prdata = 32'd0;
        if (psel && !pwrite) begin
            case (reg_sel)
                SEL_CTRL:          prdata = {30'd0, ctrl};
                SEL_STATION_LO:    prdata = station_mac[31:0];
                SEL_STATION_HI:    prdata = {16'd0, station_mac[47:32]};
                SEL_VALID_COUNT:   prdata = valid_count;
                SEL_INVALID_COUNT: prdata = invalid_count;
                SEL_DEST_LO:       prdata = parsed_mac_destination[31:0];
                SEL_DEST_HI:       prdata = {16'd0, parsed_mac_destination[47:32]};
                SEL_SRC_LO:        prdata = parsed_mac_source[31:0];
                SEL_SRC_HI:        prdata = {16'd0, parsed_mac_source[47:32]};
                default:           prdata = 32'd0;
            endcase
        end
    end

    ////////////////////////////////////////////////
    // Configuration writes, verdict and counters
    ////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ctrl           <= 2'd0;
            station_mac    <= 48'd0;
            valid_count    <= 32'd0;
            invalid_count  <= 32'd0;
            align_seen     <= 1'b0;
            valid_packet   <= 1'b0;
            invalid_packet <= 1'b0;
        end else begin
            // Framer flags misalignment one cycle ahead of done
            align_seen     <= align_error;
            valid_packet   <= frame_done && frame_good;
            invalid_packet <= frame_done && !frame_good;
            if (frame_done) begin
                if (frame_good) begin
                    valid_count <= valid_count + 32'd1;
                end else begin
                    invalid_count <= invalid_count + 32'd1;
                end
            end
            if (psel && penable && pwrite) begin
                case (reg_sel)
                    SEL_CTRL:       ctrl <= pwdata[1:0];
                    SEL_STATION_LO: station_mac[31:0] <= pwdata;
                    SEL_STATION_HI: station_mac[47:32] <= pwdata[15:0];
                    default: ;
                endcase
            end
        end
    end

    // Addresses kept for every frame past the filter, CRC aside
    always_ff @(posedge clock) begin
        if (frame_done && filter_pass) begin
            parsed_mac_destination <= dest_mac;
            parsed_mac_source      <= src_mac;
        end
    end

    // Both checkers finish on the same cycle after last
    assert property (@(posedge clock) disable iff (!rst_n) parse_done == crc_done);

endmodule

//--- verilog/crc_checker.sv
`include "eth_defines.svh"

module crc_checker (
    input  logic    clock,
    input  logic    rst_n,
    rx_byte_if.sink rx,
    output logic    crc_ok,
    output logic    done
);

    // Reflected form of the IEEE 802.3 polynomial
    localparam logic [31:0] CRC_POLY = 32'hEDB88320;

    logic [31:0] crc;
    logic [31:0] crc_seed;

    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] data);
        logic [31:0] c;
        c = crc_in ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    // Restart from all ones on the first byte
    assign crc_seed = rx.start ? 32'hFFFFFFFF : crc;

    ////////////////////////////////////////////////
    // Running CRC over the whole frame with FCS
    ////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            crc    <= 32'hFFFFFFFF;
            crc_ok <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= rx.last;
            if (rx.valid) begin
                crc <= crc_byte(crc_seed, rx.data);
            end
            if (rx.last) begin
                // Good frame leaves the fixed residue behind
                crc_ok <= crc == `ETH_CRC_RESIDUE;
            end
        end
    end

endmodule

//--- verilog/header_parser.sv
`include "eth_defines.svh"

module header_parser (
    input  logic        clock,
    input  logic        rst_n,
    rx_byte_if.sink     rx,
    output logic [47:0] dest_mac,
    output logic [47:0] src_mac,
    output logic        short_frame,
    output logic        done
);

    logic [6:0] byte_count;
    logic [6:0] byte_index;

    // Position of the current byte within the frame
    assign byte_index = rx.start ? 7'd0 : byte_count;

    ////////////////////////////////////////////////
    // Address capture, first byte lands in the MSB
    ////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (rx.valid) begin
            if (byte_index < 7'd6) begin
                dest_mac <= {dest_mac[39:0], rx.data};
            end else if (byte_index < 7'd12) begin
                src_mac <= {src_mac[39:0], rx.data};
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            byte_count  <= 7'd0;
            short_frame <= 1'b0;
            done        <= 1'b0;
        end else begin
            done <= rx.last;
            // Count saturates once the minimum length is reached
            if (rx.valid && byte_index != 7'(`ETH_MIN_FRAME)) begin
                byte_count <= byte_index + 7'd1;
            end
            if (rx.last) begin
                short_frame <= byte_count < 7'(`ETH_MIN_FRAME);
            end
        end
    end

    // Frame start is always tied to a data byte
    assert property (@(posedge clock) disable iff (!rst_n) rx.start |-> rx.valid);

endmodule

//--- verilog/rgmii_rx_framer.sv
`include "eth_defines.svh"

module rgmii_rx_framer import eth_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       enable,
    input  logic       phy_rx_data_enable,
    input  logic [3:0] phy_rx_data,
    rx_byte_if.source  rx
);

    framer_state_e state;
    logic          high_half;
    logic [3:0]    low_nibble;
    logic          first_byte;
    logic [7:0]    rx_byte;
    logic          byte_ready;

    // Byte completes while its high nibble is on the pins
    assign rx_byte    = {phy_rx_data, low_nibble};
    assign byte_ready = phy_rx_data_enable && high_half;

    always_ff @(posedge clock) begin
        if (phy_rx_data_enable && !high_half) begin
            low_nibble <= phy_rx_data;
        end
        if (state == ST_FRAME && byte_ready) begin
            rx.data <= rx_byte;
        end
    end

    ////////////////////////////////////////////////
    // Preamble search and frame streaming
    ////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            high_half      <= 1'b0;
            first_byte     <= 1'b0;
            rx.valid       <= 1'b0;
            rx.start       <= 1'b0;
            rx.last        <= 1'b0;
            rx.align_error <= 1'b0;
        end else begin
            rx.valid       <= 1'b0;
            rx.start       <= 1'b0;
            rx.last        <= 1'b0;
            rx.align_error <= 1'b0;
            high_half      <= phy_rx_data_enable ? !high_half : 1'b0;

            case (state)
                ST_IDLE: begin
                    // Port enable is sampled only at the start of a frame
                    if (phy_rx_data_enable) begin
                        state <= enable ? ST_PREAMBLE : ST_DRAIN;
                    end
                end
                ST_PREAMBLE: begin
                    if (!phy_rx_data_enable) begin
                        state <= ST_IDLE;
                    end else if (byte_ready) begin
                        if (rx_byte == `ETH_SFD) begin
                            state      <= ST_FRAME;
                            first_byte <= 1'b1;
                        end else if (rx_byte != `ETH_PREAMBLE_BYTE) begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                ST_FRAME: begin
                    if (!phy_rx_data_enable) begin
                        rx.last        <= 1'b1;
                        rx.align_error <= high_half;
                        state          <= ST_IDLE;
                    end else if (byte_ready) begin
                        rx.valid   <= 1'b1;
                        rx.start   <= first_byte;
                        first_byte <= 1'b0;
                    end
                end
                ST_DRAIN: begin
                    // Discard the rest of an unwanted frame
                    if (!phy_rx_data_enable) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // End marker never shares a cycle with a data byte
    assert property (@(posedge clock) disable iff (!rst_n) !(rx.valid && rx.last));

endmodule

//--- verilog/rx_byte_if.sv
interface rx_byte_if;

    logic [7:0] data;
    logic       valid;
    logic       start;
    // End of frame marker, no data byte with it
    logic       last;
    // Odd nibble count, qualified by last
    logic       align_error;

    modport source (
        output data,
        output valid,
        output start,
        output last,
        output align_error
    );

    modport sink (
        input data,
        input valid,
        input start,
        input last,
        input align_error
    );

endinterface

//--- verilog/eth_pkg.sv
package eth_pkg;

    // Receive framer sequencing
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_FRAME,
        ST_DRAIN
    } framer_state_e;

    // Register select decoded from paddr
    typedef enum logic [3:0] {
        SEL_CTRL,
        SEL_STATION_LO,
        SEL_STATION_HI,
        SEL_VALID_COUNT,
        SEL_INVALID_COUNT,
        SEL_DEST_LO,
        SEL_DEST_HI,
        SEL_SRC_LO,
        SEL_SRC_HI,
        SEL_NONE
    } apb_reg_e;

endpackage

//--- verilog/eth_defines.svh
`ifndef ETH_DEFINES_SVH
`define ETH_DEFINES_SVH

// Frame delimiters as seen on the wire
`define ETH_PREAMBLE_BYTE   8'h55
`define ETH_SFD             8'hD5

// Destination address through FCS
`define ETH_MIN_FRAME       64

// Reflected CRC-32 register after data plus FCS
`define ETH_CRC_RESIDUE     32'hDEBB20E3

// APB byte offsets
`define REG_CTRL            8'h00
`define REG_STATION_LO      8'h04
`define REG_STATION_HI      8'h08
`define REG_VALID_COUNT     8'h0C
`define REG_INVALID_COUNT   8'h10
`define REG_DEST_LO         8'h14
`define REG_DEST_HI         8'h18
`define REG_SRC_LO          8'h1C
`define REG_SRC_HI          8'h20

`endif
